// File: hazardDetect.f
+incdir+dv
hdl/hazardPkg.sv
hdl/opcodeDecode.sv
hdl/operandHazard.sv
hdl/issueControl.sv
hdl/hazardDetect.sv
dv/hazardDetectTb.sv

// File: dv/hazardModel.svh
// reference model of the hazard unit, included inside the testbench module to predict outputs
`ifndef HAZARD_MODEL_SVH
`define HAZARD_MODEL_SVH

// operand use of an opcode as {readsRs, readsSecond}
function automatic logic [1:0] operandUse(input logic [4:0] op);
    // stores, arith, bit-op and the 111xx set group read both fields
    if (op == 5'b10000 || op == 5'b10011 || op == 5'b11011 || op == 5'b11010
            || op[4:2] == 3'b111)
        return 2'b11;
    // lbi, halt, nop and the 001x0 jumps read nothing
    if (op == 5'b11000 || op == 5'b00000 || op == 5'b00001
            || (op[4:2] == 3'b001 && op[0] == 1'b0))
        return 2'b00;
    // 0001x reads nothing either
    if (op[4:1] == 4'b0001)
        return 2'b00;
    // branches, register jumps and the rest use rs alone
    return 2'b10;
endfunction

// only the 0001x pair ignores a branch in flight
function automatic logic ignoresBranch(input logic [4:0] op);
    return op[4:1] == 4'b0001;
endfunction

function automatic logic isStore(input logic [4:0] op);
    return op == 5'b10000 || op == 5'b10011;
endfunction

// one operand against the younger producers, result is {stall, enable, origin, source}
function automatic logic [4:0] operandResult(
    input logic [2:0] src,
    input logic [2:0] regWrt,
    input logic [2:0] dstD,
    input logic [2:0] dstX,
    input logic [2:0] dstM,
    input logic [1:0] selD,
    input logic [1:0] selX
);
    logic hitD;
    logic hitX;
    logic hitM;
    logic loadInD;
    // regWrt is ordered {decode, execute, memory}
    hitD    = regWrt[2] && dstD == src;
    hitX    = regWrt[1] && dstX == src;
    hitM    = regWrt[0] && dstM == src;
    // select 01 marks a load
    loadInD = hitD && selD == 2'b01;
    return {(hitM && !hitX) || loadInD, hitD || (hitX && !loadInD), !hitD,
            hitD ? selD : selX};
endfunction

// expected {nextInst, pcNop, fwCntrlA, fwCntrlB} one cycle after these inputs
function automatic logic [26:0] predictIssue(
    input logic [15:0] inst,
    input logic [2:0]  regWrt,
    input logic [2:0]  dstD,
    input logic [2:0]  dstX,
    input logic [2:0]  dstM,
    input logic [1:0]  selD,
    input logic [1:0]  selX,
    input logic [3:0]  branches
);
    logic [1:0] useBits;
    logic [4:0] rsRes;
    logic [4:0] secRes;
    logic       stall;
    logic [4:0] wordA;
    logic [4:0] wordB;
    useBits = operandUse(inst[15:11]);
    rsRes   = operandResult(inst[10:8], regWrt, dstD, dstX, dstM, selD, selX);
    secRes  = operandResult(inst[7:5], regWrt, dstD, dstX, dstM, selD, selX);
    stall   = (useBits[1] && rsRes[4]) || (useBits[0] && secRes[4])
            || (branches != 4'b0 && !ignoresBranch(inst[15:11]));
    // bubble is opcode 00001 with zero fields
    if (stall)
        return {16'h0800, 1'b1, 10'b0};
    wordA = useBits[1] ? {isStore(inst[15:11]), rsRes[3:0]} : 5'b0;
    wordB = useBits[0] ? {isStore(inst[15:11]), secRes[3:0]} : 5'b0;
    return {inst, 1'b0, wordA, wordB};
endfunction

`endif

// File: dv/hazardDetectTb.sv
// testbench for the hazard unit, drives random vectors and checks each one a cycle later
`timescale 1ns/1ps
`default_nettype none

module hazardDetectTb
    import hazardPkg::*;
();

    localparam int numVectors  = 2000;
    localparam int resetCycles = 5;
    // one cycle per vector plus reset, with some slack
    localparam int cycleLimit  = resetCycles + numVectors + 95;

    logic    clk;
    logic    rstN;
    instT    fetchInst;
    logic    regWrtD;
    logic    regWrtX;
    logic    regWrtM;
    regIdxT  wrtRegD;
    regIdxT  wrtRegX;
    regIdxT  wrtRegM;
    wbSelT   wbDataSelD;
    wbSelT   wbDataSelX;
    logic    branchInstD;
    logic    branchInstX;
    logic    branchInstM;
    logic    branchInstW;
    instT    nextInst;
    logic    pcNop;
    fwCntrlT fwCntrlA;
    fwCntrlT fwCntrlB;

    logic [26:0] expected;
    int          cycleCount = 0;

    `include "hazardModel.svh"

    hazardDetect hazardDetect_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hard stop if the sequence below stalls
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout, run did not finish within %0d cycles", cycleLimit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic compareField(input string testName, input logic [15:0] expectedVal,
                                input logic [15:0] actualVal);
        assert (actualVal === expectedVal) else begin
            $display("Error: %s expected %h actual %h", testName, expectedVal, actualVal);
            $display("sim failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // mostly indices 0..2 so producers and sources collide often
    function automatic regIdxT pickReg();
        if ($urandom % 8 < 6)
            return $urandom % 3;
        return $urandom % 8;
    endfunction

    task automatic driveVector();
        logic [4:0] op;
        op          = $urandom % 32;
        fetchInst   = {op, pickReg(), pickReg(), 5'($urandom % 32)};
        regWrtD     = ($urandom % 4) != 0;
        regWrtX     = ($urandom % 4) != 0;
        regWrtM     = ($urandom % 4) != 0;
        wrtRegD     = pickReg();
        wrtRegX     = pickReg();
        wrtRegM     = pickReg();
        wbDataSelD  = $urandom % 4;
        wbDataSelX  = $urandom % 4;
        // branches are rare so most vectors reach the operand rules
        branchInstD = ($urandom % 16) == 0;
        branchInstX = ($urandom % 16) == 0;
        branchInstM = ($urandom % 16) == 0;
        branchInstW = ($urandom % 16) == 0;
    endtask

    task automatic checkOutputs(input int idx);
        compareField($sformatf("vector %0d nextInst", idx), expected[26:11], nextInst);
        compareField($sformatf("vector %0d pcNop", idx), {15'd0, expected[10]}, {15'd0, pcNop});
        compareField($sformatf("vector %0d fwCntrlA", idx), {11'd0, expected[9:5]},
                     {11'd0, fwCntrlA});
        compareField($sformatf("vector %0d fwCntrlB", idx), {11'd0, expected[4:0]},
                     {11'd0, fwCntrlB});
    endtask

    initial begin
        void'($urandom(22950));
        rstN        = 1'b0;
        fetchInst   = nopInst;
        regWrtD     = 1'b0;
        regWrtX     = 1'b0;
        regWrtM     = 1'b0;
        wrtRegD     = '0;
        wrtRegX     = '0;
        wrtRegM     = '0;
        wbDataSelD  = wbSelSlbi;
        wbDataSelX  = wbSelSlbi;
        branchInstD = 1'b0;
        branchInstX = 1'b0;
        branchInstM = 1'b0;
        branchInstW = 1'b0;
        // outputs settle to the bubble while reset is low
        expected = {nopInst, 1'b0, 10'b0};
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            checkOutputs(-1);
        end
        for (int i = 0; i < numVectors; i++) begin
            @(negedge clk);
            rstN = 1'b1;
            driveVector();
            expected = predictIssue(fetchInst, {regWrtD, regWrtX, regWrtM}, wrtRegD, wrtRegX,
                                    wrtRegM, wbDataSelD, wbDataSelX,
                                    {branchInstD, branchInstX, branchInstM, branchInstW});
            // decision is registered on the next rising edge
            @(posedge clk);
            #1;
            checkOutputs(i);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/hazardDetect.sv
// hazard detection and forwarding unit top, one cycle from fetched instruction to issue decision
`timescale 1ns/1ps
`default_nettype none

module hazardDetect
    import hazardPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  instT    fetchInst,
    // producers in the younger stages
    input  logic    regWrtD,
    input  logic    regWrtX,
    input  logic    regWrtM,
    input  regIdxT  wrtRegD,
    input  regIdxT  wrtRegX,
    input  regIdxT  wrtRegM,
    input  wbSelT   wbDataSelD,
    input  wbSelT   wbDataSelX,
    // branch in flight per stage
    input  logic    branchInstD,
    input  logic    branchInstX,
    input  logic    branchInstM,
    input  logic    branchInstW,
    output instT    nextInst,
    output logic    pcNop,
    output fwCntrlT fwCntrlA,
    output fwCntrlT fwCntrlB
);

    logic   readsRs;
    logic   readsSecond;
    logic   storeOp;
    logic   branchImmune;
    logic   rsStall;
    logic   secondStall;
    fwWordT rsFw;
    fwWordT secondFw;

    opcodeDecode opcodeDecode_i (
        .fetchOpcode  (fetchInst[opcodeMsb:opcodeLsb]),
        .readsRs      (readsRs),
        .readsSecond  (readsSecond),
        .storeOp      (storeOp),
        .branchImmune (branchImmune)
    );

    // first source operand
    operandHazard rsCheck (
        .srcReg     (fetchInst[rsMsb:rsLsb]),
        .regWrtD    (regWrtD),
        .regWrtX    (regWrtX),
        .regWrtM    (regWrtM),
        .wrtRegD    (wrtRegD),
        .wrtRegX    (wrtRegX),
        .wrtRegM    (wrtRegM),
        .wbDataSelD (wbDataSelD),
        .wbDataSelX (wbDataSelX),
        .needStall  (rsStall),
        .fwWord     (rsFw)
    );

    // second operand, rt for alu ops and rd for stores
    operandHazard secondCheck (
        .srcReg     (fetchInst[secondMsb:secondLsb]),
        .regWrtD    (regWrtD),
        .regWrtX    (regWrtX),
        .regWrtM    (regWrtM),
        .wrtRegD    (wrtRegD),
        .wrtRegX    (wrtRegX),
        .wrtRegM    (wrtRegM),
        .wbDataSelD (wbDataSelD),
        .wbDataSelX (wbDataSelX),
        .needStall  (secondStall),
        .fwWord     (secondFw)
    );

    issueControl issueControl_i (
        .clk          (clk),
        .rstN         (rstN),
        .fetchInst    (fetchInst),
        .readsRs      (readsRs),
        .readsSecond  (readsSecond),
        .storeOp      (storeOp),
        .branchImmune (branchImmune),
        .rsStall      (rsStall),
        .secondStall  (secondStall),
        .rsFw         (rsFw),
        .secondFw     (secondFw),
        .branchInstD  (branchInstD),
        .branchInstX  (branchInstX),
        .branchInstM  (branchInstM),
        .branchInstW  (branchInstW),
        .nextInst     (nextInst),
        .pcNop        (pcNop),
        .fwCntrlA     (fwCntrlA),
        .fwCntrlB     (fwCntrlB)
    );

endmodule

`default_nettype wire

// File: hdl/issueControl.sv
// issue stage register of the hazard unit, merges operand checks and branch flags into stall and words
`timescale 1ns/1ps
`default_nettype none

module issueControl
    import hazardPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  instT    fetchInst,
    input  logic    readsRs,
    input  logic    readsSecond,
    input  logic    storeOp,
    input  logic    branchImmune,
    input  logic    rsStall,
    input  logic    secondStall,
    input  fwWordT  rsFw,
    input  fwWordT  secondFw,
    input  logic    branchInstD,
    input  logic    branchInstX,
    input  logic    branchInstM,
    input  logic    branchInstW,
    output instT    nextInst,
    output logic    pcNop,
    output fwCntrlT fwCntrlA,
    output fwCntrlT fwCntrlB
);

    logic    branchPending;
    logic    issueStall;
    fwCntrlT nextFwA;
    fwCntrlT nextFwB;

    // any older branch still unresolved
    assign branchPending = branchInstD | branchInstX | branchInstM | branchInstW;

    // only operands the opcode actually reads can stall it
    assign issueStall = (readsRs & rsStall) | (readsSecond & secondStall)
                      | (branchPending & ~branchImmune);

    always_comb begin
        // unused operand carries an all-zero word
        nextFwA = '0;
        nextFwB = '0;
        if (readsRs) begin
            nextFwA.storeSel = storeOp;
            nextFwA.word     = rsFw;
        end
        if (readsSecond) begin
            nextFwB.storeSel = storeOp;
            nextFwB.word     = secondFw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            nextInst <= nopInst;
            pcNop    <= 1'b0;
            fwCntrlA <= '0;
            fwCntrlB <= '0;
        end else if (issueStall) begin
            // bubble down the pipe, fetch holds its pc and retries
            nextInst <= nopInst;
            pcNop    <= 1'b1;
            fwCntrlA <= '0;
            fwCntrlB <= '0;
        end else begin
            nextInst <= fetchInst;
            pcNop    <= 1'b0;
            fwCntrlA <= nextFwA;
            fwCntrlB <= nextFwB;
        end
    end

endmodule

`default_nettype wire

// File: hdl/operandHazard.sv
// raw check for one source register against the decode, execute and memory producers
`timescale 1ns/1ps
`default_nettype none

module operandHazard
    import hazardPkg::*;
(
    input  regIdxT srcReg,
    input  logic   regWrtD,
    input  logic   regWrtX,
    input  logic   regWrtM,
    input  regIdxT wrtRegD,
    input  regIdxT wrtRegX,
    input  regIdxT wrtRegM,
    input  wbSelT  wbDataSelD,
    input  wbSelT  wbDataSelX,
    output logic   needStall,
    output fwWordT fwWord
);

    logic matchD;
    logic matchX;
    logic matchM;
    logic loadUse;

    // a stage is a producer of srcReg when it writes that register
    assign matchD = regWrtD & (wrtRegD == srcReg);
    assign matchX = regWrtX & (wrtRegX == srcReg);
    assign matchM = regWrtM & (wrtRegM == srcReg);

    // load in decode, data only exists after memory so it cannot be forwarded yet
    assign loadUse = matchD & (wbDataSelD == wbSelMem);

    // memory producer without a younger execute producer is too far to forward,
    // an execute match shadows it since that value is the newer one
    assign needStall = (matchM & ~matchX) | loadUse;

    always_comb begin
        // decode match always forwards, execute only when no load blocks it
        fwWord.fwEnable = matchD | (matchX & ~loadUse);
        // origin is the execute result for the youngest producer
        fwWord.fwOrigin = ~matchD;
        // source follows whichever stage supplies the value
        fwWord.fwSource = matchD ? wbDataSelD : wbDataSelX;
    end

endmodule

`default_nettype wire

// File: hdl/opcodeDecode.sv
// opcode classifier for the hazard unit that tells which register fields an instruction reads
`timescale 1ns/1ps
`default_nettype none

module opcodeDecode
    import hazardPkg::*;
(
    input  logic [4:0] fetchOpcode,
    output logic       readsRs,
    output logic       readsSecond,
    output logic       storeOp,
    output logic       branchImmune
);

    always_comb begin
        // branches, register jumps and anything not listed read rs only and wait on branches
        readsRs      = 1'b1;
        readsSecond  = 1'b0;
        storeOp      = 1'b0;
        branchImmune = 1'b0;

        casez (fetchOpcode)
            // stores read the base in rs and the data in the second field
            opSt, opStu: begin
                readsSecond = 1'b1;
                storeOp     = 1'b1;
            end
            // two-source alu ops
            opArith, opBitOp, opSetGroup: begin
                readsSecond = 1'b1;
            end
            // immediate load, halt, nop and pc-relative jumps need no register
            opLbi, opHalt, opNop, opJumpGroup: begin
                readsRs = 1'b0;
            end
            // siic and rti pass through even with a branch in flight
            opSiicGroup: begin
                readsRs      = 1'b0;
                branchImmune = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/hazardPkg.sv
// shared field positions, opcode patterns, select codes and types for the hazard unit; import it
`default_nettype none

package hazardPkg;

    // instruction word as it leaves fetch
    typedef logic [15:0] instT;

    // register index as found in the rs and second operand fields
    typedef logic [2:0] regIdxT;

    // write-back data select carried down the pipe with each producer
    typedef logic [1:0] wbSelT;

    // forwarding word for one operand
    // origin low picks the execute result, high picks the memory result
    typedef struct packed {
        logic  fwEnable;
        logic  fwOrigin;
        wbSelT fwSource;
    } fwWordT;

    // full control word, store select on top of the forwarding word
    typedef struct packed {
        logic   storeSel;
        fwWordT word;
    } fwCntrlT;

    // write-back select codes
    localparam wbSelT wbSelSlbi = 2'b00;
    // memory select marks a load, whose data is not ready for execute forwarding
    localparam wbSelT wbSelMem  = 2'b01;
    localparam wbSelT wbSelAlu  = 2'b10;
    localparam wbSelT wbSelImm  = 2'b11;

    // bubble inserted on a stall
    localparam instT nopInst = {5'b00001, 11'b0};

    // instruction field positions
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 11;
    localparam int rsMsb     = 10;
    localparam int rsLsb     = 8;
    localparam int secondMsb = 7;
    localparam int secondLsb = 5;

    // opcode patterns, ? bits are don't care under casez
    localparam logic [4:0] opSt           = 5'b10000;
    localparam logic [4:0] opStu          = 5'b10011;
    localparam logic [4:0] opArith        = 5'b11011;
    localparam logic [4:0] opBitOp        = 5'b11010;
    localparam logic [4:0] opSetGroup     = 5'b111??;
    localparam logic [4:0] opLbi          = 5'b11000;
    localparam logic [4:0] opHalt         = 5'b00000;
    localparam logic [4:0] opNop          = 5'b00001;
    // siic and rti never wait on a branch
    localparam logic [4:0] opSiicGroup    = 5'b0001?;
    localparam logic [4:0] opBranchGroup  = 5'b011??;
    localparam logic [4:0] opJumpRegGroup = 5'b001?1;
    localparam logic [4:0] opJumpGroup    = 5'b001?0;

endpackage

`default_nettype wire
